//--- hdl/dma_disp_params.svh
// DMA dispatcher parameters
// bus widths, channel count and the fixed feature-header values
`ifndef DMA_DISP_PARAMS_SVH
`define DMA_DISP_PARAMS_SVH

// register data and host address width
`define DMA_DATA_W 64

// byte address width of the register port, 128 words
`define DMA_ADDR_W 10

// two channels per direction
`define DMA_NUM_CHAN 2
`define DMA_CHAN_BITS 1

// afu type, end of list, feature id 1
`define DMA_DFH_HEADER 64'h1000_0100_0000_0001

// feature guid, low and high words
`define DMA_ID_LO 64'hA2C4_5E71_09B3_6D18
`define DMA_ID_HI 64'h3F8E_D05A_4B12_C967

// no further features after this one
`define DMA_NEXT_AFU_OFFSET 64'h0000_0000_0000_0000

// returned for any unmapped word
`define DMA_BADADDR_DATA 64'h0BAD_0BAD_0BAD_0BAD

`endif

//--- hdl/dma_cmd_pkg.sv
// DMA dispatcher command types
// register-port request, channel command and channel config structs
`include "dma_disp_params.svh"

package dma_cmd_pkg;

    // one register access, avalon-style
    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [`DMA_ADDR_W-1:0] address;
        logic [`DMA_DATA_W-1:0] writedata;
    } mmio_req_t;

    // transfer command, new_cmd is a single-cycle strobe
    typedef struct packed {
        logic                   new_cmd;
        logic [`DMA_DATA_W-1:0] src_start_addr;
        logic [`DMA_DATA_W-1:0] dst_start_addr;
        logic [`DMA_DATA_W-1:0] xfer_length;
    } dma_cmd_t;

    // per-direction config pulses
    typedef struct packed {
        logic sclr;
        logic clear_irq;
    } dma_cfg_t;

endpackage : dma_cmd_pkg

//--- hdl/dma_csr_pkg.sv
// DMA dispatcher register map
// word addresses of the register port and config register bit positions
`include "dma_disp_params.svh"

package dma_csr_pkg;

    // word index width, byte address minus the 8-byte offset
    localparam int CSR_WORD_W = `DMA_ADDR_W - 3;

    typedef enum logic [CSR_WORD_W-1:0] {
        // device feature header block
        CSR_DFH_HDR    = 'h00,
        CSR_ID_LO      = 'h01,
        CSR_ID_HI      = 'h02,
        CSR_NEXT_OFFS  = 'h03,
        // general
        CSR_SCRATCHPAD = 'h05,
        CSR_MAGIC_ADDR = 'h06,
        CSR_NUM_CHAN   = 'h07,
        // host-to-fpga, read direction
        CSR_RD_SRC     = 'h10,
        CSR_RD_DST     = 'h11,
        CSR_RD_LEN     = 'h12,
        CSR_RD_CFG     = 'h14,
        // fpga-to-host, write direction
        CSR_WR_SRC     = 'h20,
        CSR_WR_DST     = 'h21,
        CSR_WR_LEN     = 'h22,
        CSR_WR_CFG     = 'h24
    } csr_addr_e;

    // config register bits
    localparam int CFG_SCLR_BIT      = 0;
    localparam int CFG_CLEAR_IRQ_BIT = 1;

endpackage : dma_csr_pkg

//--- hdl/dma_csr_regs.sv
// DMA dispatcher register file
// decodes the register port, holds the programmed commands and raises command
// and config pulses for both directions
`timescale 1ns/10ps
`include "dma_disp_params.svh"

module dma_csr_regs
    import dma_cmd_pkg::*, dma_csr_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_local,
    input  mmio_req_t              req,
    output logic [`DMA_DATA_W-1:0] readdata,
    output logic                   readdatavalid,
    output dma_cmd_t               rd_cmd,
    output dma_cmd_t               wr_cmd,
    output dma_cfg_t               rd_cfg,
    output dma_cfg_t               wr_cfg,
    output logic [`DMA_DATA_W-1:0] magic_addr
);

    // direction index into the per-direction arrays
    localparam int DIR_RD = 0;
    localparam int DIR_WR = 1;

    csr_addr_e              word_addr;
    logic [`DMA_DATA_W-1:0] scratchpad;
    logic [`DMA_DATA_W-1:0] src_q [2];
    logic [`DMA_DATA_W-1:0] dst_q [2];
    logic [`DMA_DATA_W-1:0] len_q [2];
    logic [1:0]             new_cmd_q;
    dma_cfg_t               cfg_q [2];
    logic [1:0]             hit_src, hit_dst, hit_len, hit_cfg;

    // byte address in, 64-bit word index out
    assign word_addr = csr_addr_e'(req.address[`DMA_ADDR_W-1:3]);

    // per-direction write hits, bit 0 read side, bit 1 write side
    always_comb begin
        hit_src = {word_addr == CSR_WR_SRC, word_addr == CSR_RD_SRC} & {2{req.write}};
        hit_dst = {word_addr == CSR_WR_DST, word_addr == CSR_RD_DST} & {2{req.write}};
        hit_len = {word_addr == CSR_WR_LEN, word_addr == CSR_RD_LEN} & {2{req.write}};
        hit_cfg = {word_addr == CSR_WR_CFG, word_addr == CSR_RD_CFG} & {2{req.write}};
    end

    // scratchpad and magic-number address
    always_ff @(posedge clk) begin
        if (rst_local) begin
            scratchpad <= '0;
            magic_addr <= '0;
        end else if (req.write) begin
            if (word_addr == CSR_SCRATCHPAD)
                scratchpad <= req.writedata;
            if (word_addr == CSR_MAGIC_ADDR)
                magic_addr <= req.writedata;
        end
    end

    // command fields, held until rewritten
    always_ff @(posedge clk) begin
        for (int d = 0; d < 2; d++) begin
            if (hit_src[d])
                src_q[d] <= req.writedata;
            if (hit_dst[d])
                dst_q[d] <= req.writedata;
            if (hit_len[d])
                len_q[d] <= req.writedata;
        end
    end

    // self-clearing pulses
    always_ff @(posedge clk) begin
        if (rst_local) begin
            new_cmd_q <= '0;
            cfg_q[DIR_RD] <= '0;
            cfg_q[DIR_WR] <= '0;
        end else begin
            for (int d = 0; d < 2; d++) begin
                // zero length starts nothing
                new_cmd_q[d] <= hit_len[d] && (req.writedata != '0);
                cfg_q[d].sclr <= hit_cfg[d] && req.writedata[CFG_SCLR_BIT];
                cfg_q[d].clear_irq <= hit_cfg[d] && req.writedata[CFG_CLEAR_IRQ_BIT];
            end
        end
    end

    // read mux, answer one cycle later
    always_ff @(posedge clk) begin
        if (rst_local) begin
            readdata      <= '0;
            readdatavalid <= 1'b0;
        end else begin
            readdatavalid <= req.read;
            if (req.read) begin
                case (word_addr)
                    CSR_DFH_HDR:    readdata <= `DMA_DFH_HEADER;
                    CSR_ID_LO:      readdata <= `DMA_ID_LO;
                    CSR_ID_HI:      readdata <= `DMA_ID_HI;
                    CSR_NEXT_OFFS:  readdata <= `DMA_NEXT_AFU_OFFSET;
                    CSR_SCRATCHPAD: readdata <= scratchpad;
                    CSR_MAGIC_ADDR: readdata <= magic_addr;
                    CSR_NUM_CHAN:   readdata <= `DMA_DATA_W'(`DMA_NUM_CHAN);
                    CSR_RD_SRC:     readdata <= src_q[DIR_RD];
                    CSR_RD_DST:     readdata <= dst_q[DIR_RD];
                    CSR_RD_LEN:     readdata <= len_q[DIR_RD];
                    CSR_WR_SRC:     readdata <= src_q[DIR_WR];
                    CSR_WR_DST:     readdata <= dst_q[DIR_WR];
                    CSR_WR_LEN:     readdata <= len_q[DIR_WR];
                    // config words are write-only
                    default:        readdata <= `DMA_BADADDR_DATA;
                endcase
            end
        end
    end

    // programmed commands out to the splitters
    assign rd_cmd = '{new_cmd: new_cmd_q[DIR_RD], src_start_addr: src_q[DIR_RD],
                      dst_start_addr: dst_q[DIR_RD], xfer_length: len_q[DIR_RD]};
    assign wr_cmd = '{new_cmd: new_cmd_q[DIR_WR], src_start_addr: src_q[DIR_WR],
                      dst_start_addr: dst_q[DIR_WR], xfer_length: len_q[DIR_WR]};
    assign rd_cfg = cfg_q[DIR_RD];
    assign wr_cfg = cfg_q[DIR_WR];

endmodule : dma_csr_regs

//--- hdl/dma_cmd_splitter.sv
// DMA command splitter
// divides one transfer between two channels, channel 0 takes the odd byte
`timescale 1ns/10ps
`include "dma_disp_params.svh"

module dma_cmd_splitter
    import dma_cmd_pkg::*;
(
    input  logic     clk,
    input  logic     rst_local,
    input  dma_cmd_t cmd,
    output dma_cmd_t chan_cmd [`DMA_NUM_CHAN],
    output logic     only_ch0
);

    logic [1:0]             stb_d;
    logic [1:0]             chan_stb;
    logic [`DMA_DATA_W-1:0] src_q, dst_q;
    logic [`DMA_DATA_W-1:0] len_ch0, len_ch1;
    logic [`DMA_DATA_W-1:0] src_ch1, dst_ch1;

    // strobe pipeline, stage 3 issues both channels together
    always_ff @(posedge clk) begin
        if (rst_local) begin
            stb_d    <= '0;
            chan_stb <= '0;
            only_ch0 <= 1'b0;
        end else begin
            stb_d <= {stb_d[0], cmd.new_cmd};
            // channel 1 stays quiet when its half is empty
            chan_stb <= {stb_d[1] && (len_ch1 != '0), stb_d[1]};
            // known one cycle after the strobe, held until the next command
            if (cmd.new_cmd)
                only_ch0 <= (cmd.xfer_length >> `DMA_CHAN_BITS) == '0;
        end
    end

    always_ff @(posedge clk) begin
        // stage 1: capture bases, split the length
        if (cmd.new_cmd) begin
            src_q   <= cmd.src_start_addr;
            dst_q   <= cmd.dst_start_addr;
            len_ch1 <= cmd.xfer_length >> `DMA_CHAN_BITS;
            len_ch0 <= (cmd.xfer_length >> `DMA_CHAN_BITS)
                       + cmd.xfer_length[`DMA_CHAN_BITS-1:0];
        end
        // stage 2: channel 1 starts where channel 0 ends
        if (stb_d[0]) begin
            src_ch1 <= src_q + len_ch0;
            dst_ch1 <= dst_q + len_ch0;
        end
    end

    assign chan_cmd[0] = '{new_cmd: chan_stb[0], src_start_addr: src_q,
                           dst_start_addr: dst_q, xfer_length: len_ch0};
    assign chan_cmd[1] = '{new_cmd: chan_stb[1], src_start_addr: src_ch1,
                           dst_start_addr: dst_ch1, xfer_length: len_ch1};

endmodule : dma_cmd_splitter

//--- hdl/dma_done_tracker.sv
// DMA completion tracker
// waits for every channel that got a command to report done, then pulses once
`timescale 1ns/10ps
`include "dma_disp_params.svh"

module dma_done_tracker (
    input  logic                     clk,
    input  logic                     rst_local,
    input  logic [`DMA_NUM_CHAN-1:0] chan_new_cmd,
    input  logic                     only_ch0,
    input  logic                     cmd_start,
    input  logic [`DMA_NUM_CHAN-1:0] chan_done,
    output logic                     xfer_done
);

    logic [`DMA_NUM_CHAN-1:0] waiting;
    logic [`DMA_NUM_CHAN-1:0] received;
    logic [`DMA_NUM_CHAN-1:0] only_mask;

    // short transfer, channels above 0 count as issued and finished
    assign only_mask = {{(`DMA_NUM_CHAN-1){only_ch0}}, 1'b0};

    always_ff @(posedge clk) begin
        if (rst_local) begin
            waiting   <= '0;
            received  <= '0;
            xfer_done <= 1'b0;
        end else begin
            // single pulse, the flags drop on the following edge
            xfer_done <= !xfer_done && (&(waiting & received));

            if (xfer_done)
                waiting <= '0;
            else
                waiting <= waiting | chan_new_cmd | only_mask;

            // a fresh command discards completions of the old one
            if (xfer_done || cmd_start)
                received <= '0;
            else
                received <= received | chan_done | only_mask;
        end
    end

endmodule : dma_done_tracker

//--- hdl/dma_dispatcher.sv
// DMA dispatcher top
// register file plus one splitter and one done tracker per direction
`timescale 1ns/10ps
`include "dma_disp_params.svh"

module dma_dispatcher
    import dma_cmd_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_local,
    input  mmio_req_t                mmio_req,
    output logic [`DMA_DATA_W-1:0]   readdata,
    output logic                     readdatavalid,
    output dma_cmd_t                 rd_chan_cmd [`DMA_NUM_CHAN],
    output dma_cmd_t                 wr_chan_cmd [`DMA_NUM_CHAN],
    output dma_cfg_t                 rd_cfg,
    output dma_cfg_t                 wr_cfg,
    output logic [`DMA_DATA_W-1:0]   magic_addr,
    // write side: bit 0 is the magic-number pulse, bit 1 the irq
    input  logic [`DMA_NUM_CHAN-1:0] rd_chan_done,
    input  logic [`DMA_NUM_CHAN-1:0] wr_chan_done,
    output logic                     host_mem_rd_xfer_done,
    output logic                     host_mem_wr_xfer_done
);

    dma_cmd_t                 rd_cmd, wr_cmd;
    logic                     rd_only_ch0, wr_only_ch0;
    logic [`DMA_NUM_CHAN-1:0] rd_chan_stb, wr_chan_stb;

    // channel strobes gathered for the trackers
    assign rd_chan_stb = {rd_chan_cmd[1].new_cmd, rd_chan_cmd[0].new_cmd};
    assign wr_chan_stb = {wr_chan_cmd[1].new_cmd, wr_chan_cmd[0].new_cmd};

    dma_csr_regs csr_inst (
        .clk, .rst_local,
        .req (mmio_req),
        .readdata, .readdatavalid,
        .rd_cmd, .wr_cmd,
        .rd_cfg, .wr_cfg,
        .magic_addr
    );

    // host-to-fpga
    dma_cmd_splitter rd_split_inst (
        .clk, .rst_local,
        .cmd (rd_cmd), .chan_cmd (rd_chan_cmd), .only_ch0 (rd_only_ch0)
    );

    dma_done_tracker rd_done_inst (
        .clk, .rst_local,
        .chan_new_cmd (rd_chan_stb), .only_ch0 (rd_only_ch0),
        .cmd_start (rd_cmd.new_cmd), .chan_done (rd_chan_done),
        .xfer_done (host_mem_rd_xfer_done)
    );

    // fpga-to-host
    dma_cmd_splitter wr_split_inst (
        .clk, .rst_local,
        .cmd (wr_cmd), .chan_cmd (wr_chan_cmd), .only_ch0 (wr_only_ch0)
    );

    dma_done_tracker wr_done_inst (
        .clk, .rst_local,
        .chan_new_cmd (wr_chan_stb), .only_ch0 (wr_only_ch0),
        .cmd_start (wr_cmd.new_cmd), .chan_done (wr_chan_done),
        .xfer_done (host_mem_wr_xfer_done)
    );

endmodule : dma_dispatcher

//--- tests/dma_dispatcher_chk.sv
// DMA dispatcher protocol checker
// read strobe timing, single-cycle strobes and channel pairing
`timescale 1ns/10ps

module dma_dispatcher_chk
    import dma_cmd_pkg::*;
(
    input logic       clk,
    input logic       rst_local,
    input mmio_req_t  mmio_req,
    input logic       readdatavalid,
    // wr ch1, wr ch0, rd ch1, rd ch0
    input logic [3:0] chan_stb,
    // wr, rd
    input logic [1:0] xfer_done
);

    // failed assertion count
    int fail_cnt = 0;

    // valid strobe trails each read by one cycle, never otherwise
    a_rdv_after_read: assert property (@(posedge clk) disable iff (rst_local)
        mmio_req.read |=> readdatavalid)
        else begin
            $error("readdatavalid missing one cycle after a read");
            fail_cnt++;
        end
    a_rdv_no_read: assert property (@(posedge clk) disable iff (rst_local)
        !mmio_req.read |=> !readdatavalid)
        else begin
            $error("readdatavalid without a read");
            fail_cnt++;
        end

    for (genvar i = 0; i < 4; i++) begin : g_stb
        a_stb_pulse: assert property (@(posedge clk) disable iff (rst_local)
            chan_stb[i] |=> !chan_stb[i])
            else begin
                $error("channel new_cmd %0d longer than one cycle", i);
                fail_cnt++;
            end
    end

    for (genvar d = 0; d < 2; d++) begin : g_dir
        a_done_pulse: assert property (@(posedge clk) disable iff (rst_local)
            xfer_done[d] |=> !xfer_done[d])
            else begin
                $error("xfer_done %0d longer than one cycle", d);
                fail_cnt++;
            end
        // ch1 only ever issues alongside ch0
        a_ch1_with_ch0: assert property (@(posedge clk) disable iff (rst_local)
            chan_stb[2*d+1] |-> chan_stb[2*d])
            else begin
                $error("channel 1 new_cmd without channel 0, direction %0d", d);
                fail_cnt++;
            end
    end

endmodule : dma_dispatcher_chk

bind dma_dispatcher dma_dispatcher_chk chk_inst (
    .clk, .rst_local, .mmio_req, .readdatavalid,
    .chan_stb ({wr_chan_cmd[1].new_cmd, wr_chan_cmd[0].new_cmd,
                rd_chan_cmd[1].new_cmd, rd_chan_cmd[0].new_cmd}),
    .xfer_done ({host_mem_wr_xfer_done, host_mem_rd_xfer_done})
);

//--- tests/tb_dma_dispatcher.sv
// DMA dispatcher testbench
// register reads, table-driven command splits and channel completion models
`timescale 1ns/10ps
`include "dma_disp_params.svh"

module tb_dma_dispatcher
    import dma_cmd_pkg::*, dma_csr_pkg::*;
();

    // one transfer per row, ch1_first sets the completion order
    typedef struct packed {
        logic                   dir;
        logic [`DMA_DATA_W-1:0] src;
        logic [`DMA_DATA_W-1:0] dst;
        logic [`DMA_DATA_W-1:0] len;
        logic                   ch1_first;
    } xfer_row_t;

    logic                     clk;
    logic                     rst_local;
    mmio_req_t                mmio_req;
    logic [`DMA_DATA_W-1:0]   readdata;
    logic                     readdatavalid;
    dma_cmd_t                 rd_chan_cmd [`DMA_NUM_CHAN];
    dma_cmd_t                 wr_chan_cmd [`DMA_NUM_CHAN];
    dma_cfg_t                 rd_cfg, wr_cfg;
    logic [`DMA_DATA_W-1:0]   magic_addr;
    logic [`DMA_NUM_CHAN-1:0] rd_chan_done, wr_chan_done;
    logic                     host_mem_rd_xfer_done, host_mem_wr_xfer_done;
    xfer_row_t                rows [8];
    int                       done_cnt [2] = '{0, 0};
    int                       errors;
    int                       errs_before;
    integer                   seed;

    dma_dispatcher dma_dispatcher_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // done pulses counted mid-cycle
    always @(negedge clk) begin
        if (host_mem_rd_xfer_done)
            done_cnt[0] <= done_cnt[0] + 1;
        if (host_mem_wr_xfer_done)
            done_cnt[1] <= done_cnt[1] + 1;
    end

    function automatic logic [`DMA_ADDR_W-1:0] byte_addr(input csr_addr_e w);
        return {w, 3'b000};
    endfunction

    function automatic logic [1:0] chan_stb(input logic dir);
        if (dir)
            return {wr_chan_cmd[1].new_cmd, wr_chan_cmd[0].new_cmd};
        return {rd_chan_cmd[1].new_cmd, rd_chan_cmd[0].new_cmd};
    endfunction

    task automatic check_value(input string name, input logic [`DMA_DATA_W-1:0] got,
                               input logic [`DMA_DATA_W-1:0] exp);
        assert (got === exp)
        else begin
            $display("ERR %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cond(input bit ok, input string what);
        assert (ok)
        else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic write_reg(input csr_addr_e w, input logic [`DMA_DATA_W-1:0] data);
        @(negedge clk);
        mmio_req = '{read: 1'b0, write: 1'b1, address: byte_addr(w), writedata: data};
        @(negedge clk);
        mmio_req = '0;
    endtask

    task automatic read_check(input string name, input logic [`DMA_ADDR_W-1:0] addr,
                              input logic [`DMA_DATA_W-1:0] exp);
        @(negedge clk);
        mmio_req = '{read: 1'b1, write: 1'b0, address: addr, writedata: '0};
        @(negedge clk);
        mmio_req = '0;
        // answer is due exactly one cycle after the read
        check_cond(readdatavalid, "readdatavalid did not follow the read");
        check_value(name, readdata, exp);
    endtask

    // one completion pulse, write side ch0 stands for the magic-number pulse
    task automatic pulse_done(input logic dir, input int ch);
        @(negedge clk);
        if (dir)
            wr_chan_done[ch] = 1'b1;
        else
            rd_chan_done[ch] = 1'b1;
        @(negedge clk);
        rd_chan_done = '0;
        wr_chan_done = '0;
    endtask

    task automatic run_row(input int idx, input xfer_row_t r);
        logic [`DMA_DATA_W-1:0] l0, l1;
        dma_cmd_t               c0, c1;
        int                     cnt, base, obase, first, gap;
        bit                     two_ch;
        errs_before = errors;
        // channel 0 takes half plus the odd byte
        l1 = r.len >> 1;
        l0 = l1 + r.len[0];
        two_ch = (l1 != 0);
        base = done_cnt[r.dir];
        obase = done_cnt[!r.dir];
        write_reg(r.dir ? CSR_WR_SRC : CSR_RD_SRC, r.src);
        write_reg(r.dir ? CSR_WR_DST : CSR_RD_DST, r.dst);
        write_reg(r.dir ? CSR_WR_LEN : CSR_RD_LEN, r.len);
        // edges from the sampled length write to the channel strobes
        cnt = 1;
        while (chan_stb(r.dir) == 2'b00 && cnt < 12) begin
            @(negedge clk);
            cnt++;
        end
        if (r.len == 0) begin
            check_cond(cnt == 12, "zero length issued a channel command");
            check_value("xfer_done_count", done_cnt[r.dir] - base, 0);
        end else if (cnt == 12) begin
            check_cond(1'b0,
                       $sformatf("timeout waiting for channel commands in case %0d", idx));
        end else begin
            c0 = r.dir ? wr_chan_cmd[0] : rd_chan_cmd[0];
            c1 = r.dir ? wr_chan_cmd[1] : rd_chan_cmd[1];
            check_value("cmd_latency", cnt, 4);
            check_value("ch0.new_cmd", c0.new_cmd, 1'b1);
            check_value("ch0.src_start_addr", c0.src_start_addr, r.src);
            check_value("ch0.dst_start_addr", c0.dst_start_addr, r.dst);
            check_value("ch0.xfer_length", c0.xfer_length, l0);
            check_value("ch1.new_cmd", c1.new_cmd, two_ch);
            if (two_ch) begin
                check_value("ch1.src_start_addr", c1.src_start_addr, r.src + l0);
                check_value("ch1.dst_start_addr", c1.dst_start_addr, r.dst + l0);
                check_value("ch1.xfer_length", c1.xfer_length, l1);
            end
            first = (r.ch1_first && two_ch) ? 1 : 0;
            repeat (1 + $unsigned($random(seed)) % 6) @(negedge clk);
            pulse_done(r.dir, first);
            if (two_ch) begin
                repeat (1 + $unsigned($random(seed)) % 6) @(negedge clk);
                check_value("xfer_done_early", done_cnt[r.dir], base);
                pulse_done(r.dir, 1 - first);
            end
            gap = 0;
            while (done_cnt[r.dir] == base && gap < 20) begin
                @(negedge clk);
                gap++;
            end
            check_cond(gap < 20, "timeout waiting for xfer_done");
            // a second pulse would show up here
            repeat (6) @(negedge clk);
            check_value("xfer_done_count", done_cnt[r.dir] - base, 1);
        end
        check_value("other_xfer_done_count", done_cnt[!r.dir], obase);
        read_check("src_readback", byte_addr(r.dir ? CSR_WR_SRC : CSR_RD_SRC), r.src);
        read_check("dst_readback", byte_addr(r.dir ? CSR_WR_DST : CSR_RD_DST), r.dst);
        read_check("len_readback", byte_addr(r.dir ? CSR_WR_LEN : CSR_RD_LEN), r.len);
        $display("case %0d dir %0d len %0h: %0d errors", idx, r.dir, r.len,
                 errors - errs_before);
    endtask

    initial begin
        errors = 0;
        seed = 32'hfd45f8c7;
        rst_local = 1'b1;
        mmio_req = '0;
        rd_chan_done = '0;
        wr_chan_done = '0;
        // dir, src, dst, len, ch1_first
        rows[0] = '{1'b0, 64'h1000_0000, 64'h2000, 64'h100, 1'b0};
        rows[1] = '{1'b0, 64'h4000, 64'h8000_0000, 64'h3b, 1'b1};
        rows[2] = '{1'b1, 64'h10, 64'h7_0000_0000, 64'h1000, 1'b1};
        rows[3] = '{1'b1, 64'h3_0000, 64'h5_0040, 64'h201, 1'b0};
        rows[4] = '{1'b0, 64'h600, 64'h900, 64'h1, 1'b1};
        rows[5] = '{1'b1, 64'h700, 64'hA00, 64'h1, 1'b0};
        rows[6] = '{1'b0, 64'h800, 64'hB00, 64'h0, 1'b0};
        rows[7] = '{1'b1, 64'h900, 64'hC00, 64'h0, 1'b0};
        repeat (5) @(negedge clk);
        rst_local = 1'b0;

        // idle outputs and read-only words
        check_value("readdata", readdata, '0);
        check_value("readdatavalid", readdatavalid, 1'b0);
        check_value("magic_addr", magic_addr, '0);
        check_value("chan_new_cmd", {chan_stb(1), chan_stb(0)}, '0);
        check_value("xfer_done", {host_mem_wr_xfer_done, host_mem_rd_xfer_done}, '0);
        check_value("cfg", {wr_cfg, rd_cfg}, '0);
        read_check("dfh_header", byte_addr(CSR_DFH_HDR), `DMA_DFH_HEADER);
        read_check("id_lo", byte_addr(CSR_ID_LO), `DMA_ID_LO);
        read_check("id_hi", byte_addr(CSR_ID_HI), `DMA_ID_HI);
        read_check("next_afu_offset", byte_addr(CSR_NEXT_OFFS), `DMA_NEXT_AFU_OFFSET);
        read_check("num_chan", byte_addr(CSR_NUM_CHAN), `DMA_NUM_CHAN);
        read_check("scratchpad", byte_addr(CSR_SCRATCHPAD), '0);
        read_check("unmapped", 10'h020, `DMA_BADADDR_DATA);
        $display("case 0 reset and id reads: %0d errors", errors);

        errs_before = errors;
        write_reg(CSR_SCRATCHPAD, 64'hDEAD_BEEF_0123_4567);
        read_check("scratchpad", byte_addr(CSR_SCRATCHPAD), 64'hDEAD_BEEF_0123_4567);
        write_reg(CSR_MAGIC_ADDR, 64'h0000_00F0_0000_1000);
        check_value("magic_addr", magic_addr, 64'h0000_00F0_0000_1000);
        read_check("magic_addr_readback", byte_addr(CSR_MAGIC_ADDR),
                   64'h0000_00F0_0000_1000);
        $display("case 1 scratchpad and magic: %0d errors", errors - errs_before);

        for (int i = 0; i < 8; i++)
            run_row(i + 2, rows[i]);

        // config pulses only on the addressed direction
        errs_before = errors;
        write_reg(CSR_RD_CFG, 64'h3);
        check_value("cfg", {wr_cfg, rd_cfg}, 4'b0011);
        @(negedge clk);
        check_value("cfg", {wr_cfg, rd_cfg}, 4'b0000);
        write_reg(CSR_WR_CFG, 64'h1 << CFG_SCLR_BIT);
        check_value("cfg", {wr_cfg, rd_cfg}, 4'b1000);
        write_reg(CSR_WR_CFG, 64'h1 << CFG_CLEAR_IRQ_BIT);
        check_value("cfg", {wr_cfg, rd_cfg}, 4'b0100);
        @(negedge clk);
        check_value("cfg", {wr_cfg, rd_cfg}, 4'b0000);
        $display("case 10 config pulses: %0d errors", errors - errs_before);

        errors = errors + dma_dispatcher_inst.chk_inst.fail_cnt;
        $display("11 cases run, %0d errors", errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule : tb_dma_dispatcher

//--- filelist.f
+incdir+hdl
hdl/dma_cmd_pkg.sv
hdl/dma_csr_pkg.sv
hdl/dma_csr_regs.sv
hdl/dma_cmd_splitter.sv
hdl/dma_done_tracker.sv
hdl/dma_dispatcher.sv
tests/dma_dispatcher_chk.sv
tests/tb_dma_dispatcher.sv

//--- Bender.yml
package:
  name: dma_dispatcher

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dma_cmd_pkg.sv
      - hdl/dma_csr_pkg.sv
      - hdl/dma_csr_regs.sv
      - hdl/dma_cmd_splitter.sv
      - hdl/dma_done_tracker.sv
      - hdl/dma_dispatcher.sv
      - target: test
        files:
          - tests/dma_dispatcher_chk.sv
          - tests/tb_dma_dispatcher.sv
